// File: Makefile
TOP = id_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

// File: all.f
+incdir+logic
logic/decode_pkg.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/id_stage.sv
testbench/id_stage_checker.sv
testbench/id_stage_tb.sv

// File: logic/branch_unit.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module branch_unit (
    input  logic                ds_valid_go,
    input  decode_pkg::word_t   pc,
    input  logic [`IMM_W-1:0]   imm,
    input  logic [25:0]         jidx,
    input  decode_pkg::word_t   rs_value,
    input  decode_pkg::word_t   rt_value,
    input  logic                is_beq,
    input  logic                is_bne,
    input  logic                is_j,
    input  logic                is_jal,
    input  logic                is_jr,
    output logic                br_taken,
    output decode_pkg::word_t   br_target
);
    import decode_pkg::*;

    word_t slot_pc;  // delay slot address
    word_t br_offset;
    logic  rs_eq_rt;

    assign slot_pc   = pc + word_t'(4);
    assign br_offset = {{(`DATA_W-`IMM_W-2){imm[`IMM_W-1]}}, imm, 2'b00};
    assign rs_eq_rt  = (rs_value == rt_value);

    assign br_taken = ds_valid_go & (is_beq & rs_eq_rt | is_bne & ~rs_eq_rt
                                   | is_j | is_jal | is_jr);

    assign br_target = (is_beq | is_bne) ? slot_pc + br_offset :
                       is_jr             ? rs_value :
                                           {slot_pc[31:28], jidx, 2'b00};  // j, jal

endmodule

// File: logic/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// datapath and register file sizes
`define DATA_W      32
`define REG_ADDR_W  5
`define REG_COUNT   32

// instruction field widths
`define IMM_W       16

// jal writes its return address here
`define LINK_REG    31

`endif

// File: logic/decode_pkg.sv
`include "decode_defs.svh"

package decode_pkg;

    typedef logic [`DATA_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,  // R-type, see funct
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field of SPECIAL, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    // operation carried to the execute stage
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR,  ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

endpackage

// File: logic/id_stage.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module id_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fs_to_ds_valid,
    input  decode_pkg::word_t     fs_inst,
    input  decode_pkg::word_t     fs_pc,
    input  logic                  es_allowin,
    input  decode_pkg::reg_addr_t es_dest,
    input  decode_pkg::word_t     es_result,
    input  logic                  es_result_valid,
    input  decode_pkg::reg_addr_t ms_dest,
    input  decode_pkg::word_t     ms_result,
    input  logic                  ws_we,
    input  decode_pkg::reg_addr_t ws_dest,
    input  decode_pkg::word_t     ws_data,
    output logic                  ds_allowin,
    output logic                  ds_to_es_valid,
    output decode_pkg::alu_op_e   alu_op,
    output logic                  src1_is_sa,
    output logic                  src1_is_pc,
    output logic                  src2_is_imm,
    output logic                  src2_is_8,
    output logic                  gr_we,
    output logic                  mem_re,
    output logic                  mem_we,
    output decode_pkg::reg_addr_t dest,
    output logic [`IMM_W-1:0]     imm,
    output decode_pkg::word_t     rs_value,
    output decode_pkg::word_t     rt_value,
    output decode_pkg::word_t     ds_pc,
    output logic                  br_taken,
    output decode_pkg::word_t     br_target
);
    import decode_pkg::*;

    logic        ds_valid;
    logic        ready_go;
    word_t       ds_inst;
    reg_addr_t   rs, rt;
    logic [25:0] jidx;
    logic        uses_rs, uses_rt;
    logic        is_beq, is_bne, is_j, is_jal, is_jr;
    word_t       rf_rdata1, rf_rdata2;

    assign ds_allowin     = !ds_valid || (ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    inst_decoder u_decoder (
        .inst(ds_inst), .rs(rs), .rt(rt), .alu_op(alu_op),
        .src1_is_sa(src1_is_sa), .src1_is_pc(src1_is_pc),
        .src2_is_imm(src2_is_imm), .src2_is_8(src2_is_8),
        .gr_we(gr_we), .mem_re(mem_re), .mem_we(mem_we), .dest(dest),
        .imm(imm), .jidx(jidx), .uses_rs(uses_rs), .uses_rt(uses_rt),
        .is_beq(is_beq), .is_bne(is_bne), .is_j(is_j), .is_jal(is_jal), .is_jr(is_jr)
    );

    regfile u_regfile (
        .clk(clk), .we(ws_we), .waddr(ws_dest), .wdata(ws_data),
        .raddr1(rs), .raddr2(rt), .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    operand_bypass u_bypass (
        .rs(rs), .rt(rt), .uses_rs(uses_rs), .uses_rt(uses_rt),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .es_dest(es_dest), .es_result(es_result), .es_result_valid(es_result_valid),
        .ms_dest(ms_dest), .ms_result(ms_result),
        .ws_we(ws_we), .ws_dest(ws_dest), .ws_data(ws_data),
        .rs_value(rs_value), .rt_value(rt_value), .ready_go(ready_go)
    );

    // resolve only once the operands are final
    branch_unit u_branch (
        .ds_valid_go(ds_to_es_valid), .pc(ds_pc), .imm(imm), .jidx(jidx),
        .rs_value(rs_value), .rt_value(rt_value),
        .is_beq(is_beq), .is_bne(is_bne), .is_j(is_j), .is_jal(is_jal), .is_jr(is_jr),
        .br_taken(br_taken), .br_target(br_target)
    );

endmodule

// File: logic/inst_decoder.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module inst_decoder (
    input  decode_pkg::word_t     inst,
    output decode_pkg::reg_addr_t rs,
    output decode_pkg::reg_addr_t rt,
    output decode_pkg::alu_op_e   alu_op,
    output logic                  src1_is_sa,
    output logic                  src1_is_pc,
    output logic                  src2_is_imm,
    output logic                  src2_is_8,
    output logic                  gr_we,
    output logic                  mem_re,
    output logic                  mem_we,
    output decode_pkg::reg_addr_t dest,
    output logic [`IMM_W-1:0]     imm,
    output logic [25:0]           jidx,
    output logic                  uses_rs,
    output logic                  uses_rt,
    output logic                  is_beq,
    output logic                  is_bne,
    output logic                  is_j,
    output logic                  is_jal,
    output logic                  is_jr
);
    import decode_pkg::*;

    opcode_e   op;
    funct_e    func;
    reg_addr_t rd;
    reg_addr_t sa;
    logic      special;
    logic      sa_zero;
    logic      rs_zero;
    logic inst_addu, inst_subu, inst_slt, inst_sltu, inst_and, inst_or;
    logic inst_xor, inst_nor, inst_sll, inst_srl, inst_sra;
    logic inst_sllv, inst_srlv, inst_srav;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori;
    logic inst_lui, inst_lw, inst_sw;
    logic dst_is_rt;
    logic reads_both;  // rs and rt both sourced

    assign op   = opcode_e'(inst[31:26]);
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = funct_e'(inst[5:0]);
    assign imm  = inst[15:0];
    assign jidx = inst[25:0];

    assign special = (op == OP_SPECIAL);
    assign sa_zero = (sa == '0);
    assign rs_zero = (rs == '0);

    // three-register ops need sa == 0, shifts by sa need rs == 0
    assign inst_addu  = special && func == FN_ADDU && sa_zero;
    assign inst_subu  = special && func == FN_SUBU && sa_zero;
    assign inst_slt   = special && func == FN_SLT  && sa_zero;
    assign inst_sltu  = special && func == FN_SLTU && sa_zero;
    assign inst_and   = special && func == FN_AND  && sa_zero;
    assign inst_or    = special && func == FN_OR   && sa_zero;
    assign inst_xor   = special && func == FN_XOR  && sa_zero;
    assign inst_nor   = special && func == FN_NOR  && sa_zero;
    assign inst_sllv  = special && func == FN_SLLV && sa_zero;
    assign inst_srlv  = special && func == FN_SRLV && sa_zero;
    assign inst_srav  = special && func == FN_SRAV && sa_zero;
    assign inst_sll   = special && func == FN_SLL  && rs_zero;
    assign inst_srl   = special && func == FN_SRL  && rs_zero;
    assign inst_sra   = special && func == FN_SRA  && rs_zero;
    assign is_jr      = special && func == FN_JR && rt == '0 && rd == '0 && sa_zero;
    assign inst_addiu = (op == OP_ADDIU);
    assign inst_slti  = (op == OP_SLTI);
    assign inst_sltiu = (op == OP_SLTIU);
    assign inst_andi  = (op == OP_ANDI);
    assign inst_ori   = (op == OP_ORI);
    assign inst_xori  = (op == OP_XORI);
    assign inst_lui   = (op == OP_LUI) && rs_zero;
    assign inst_lw    = (op == OP_LW);
    assign inst_sw    = (op == OP_SW);
    assign is_beq     = (op == OP_BEQ);
    assign is_bne     = (op == OP_BNE);
    assign is_j       = (op == OP_J);
    assign is_jal     = (op == OP_JAL);

    always_comb begin
        alu_op = ALU_ADD;  // addu/addiu, address calc, jal link
        if (inst_subu)                   alu_op = ALU_SUB;
        else if (inst_slt  | inst_slti)  alu_op = ALU_SLT;
        else if (inst_sltu | inst_sltiu) alu_op = ALU_SLTU;
        else if (inst_and  | inst_andi)  alu_op = ALU_AND;
        else if (inst_nor)               alu_op = ALU_NOR;
        else if (inst_or   | inst_ori)   alu_op = ALU_OR;
        else if (inst_xor  | inst_xori)  alu_op = ALU_XOR;
        else if (inst_sll  | inst_sllv)  alu_op = ALU_SLL;
        else if (inst_srl  | inst_srlv)  alu_op = ALU_SRL;
        else if (inst_sra  | inst_srav)  alu_op = ALU_SRA;
        else if (inst_lui)               alu_op = ALU_LUI;
    end

    assign src1_is_sa  = inst_sll | inst_srl | inst_sra;
    assign src1_is_pc  = is_jal;  // link value is pc + 8
    assign src2_is_8   = is_jal;
    assign src2_is_imm = |{inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori,
                           inst_xori, inst_lui, inst_lw, inst_sw};
    assign mem_re      = inst_lw;
    assign mem_we      = inst_sw;

    assign dst_is_rt = |{inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori,
                         inst_xori, inst_lui, inst_lw};
    assign gr_we     = dst_is_rt | is_jal | inst_sll | inst_srl | inst_sra
                     | |{inst_addu, inst_subu, inst_slt, inst_sltu, inst_and, inst_or,
                         inst_xor, inst_nor, inst_sllv, inst_srlv, inst_srav};
    assign dest = is_jal    ? reg_addr_t'(`LINK_REG) :
                  dst_is_rt ? rt : rd;

    // source classes for the load-use check, sw reads its base too
    assign reads_both = |{inst_addu, inst_subu, inst_slt, inst_sltu, inst_and, inst_or,
                          inst_xor, inst_nor, inst_sllv, inst_srlv, inst_srav,
                          is_beq, is_bne, inst_sw};
    assign uses_rs = reads_both | is_jr
                   | |{inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori,
                       inst_xori, inst_lw};
    assign uses_rt = reads_both | inst_sll | inst_srl | inst_sra;

endmodule

// File: logic/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
    input  decode_pkg::reg_addr_t rs,
    input  decode_pkg::reg_addr_t rt,
    input  logic                  uses_rs,
    input  logic                  uses_rt,
    input  decode_pkg::word_t     rf_rdata1,
    input  decode_pkg::word_t     rf_rdata2,
    input  decode_pkg::reg_addr_t es_dest,
    input  decode_pkg::word_t     es_result,
    input  logic                  es_result_valid,
    input  decode_pkg::reg_addr_t ms_dest,
    input  decode_pkg::word_t     ms_result,
    input  logic                  ws_we,
    input  decode_pkg::reg_addr_t ws_dest,
    input  decode_pkg::word_t     ws_data,
    output decode_pkg::word_t     rs_value,
    output decode_pkg::word_t     rt_value,
    output logic                  ready_go
);
    import decode_pkg::*;

    logic rs_hit_es, rs_hit_ms, rs_hit_ws;
    logic rt_hit_es, rt_hit_ms, rt_hit_ws;
    logic load_use;

    // a nonzero source equal to a dest implies that dest is nonzero
    assign rs_hit_es = (rs != '0) && (rs == es_dest);
    assign rs_hit_ms = (rs != '0) && (rs == ms_dest);
    assign rs_hit_ws = (rs != '0) && (rs == ws_dest) && ws_we;
    assign rt_hit_es = (rt != '0) && (rt == es_dest);
    assign rt_hit_ms = (rt != '0) && (rt == ms_dest);
    assign rt_hit_ws = (rt != '0) && (rt == ws_dest) && ws_we;

    // youngest result wins
    assign rs_value = rs_hit_es ? es_result :
                      rs_hit_ms ? ms_result :
                      rs_hit_ws ? ws_data   : rf_rdata1;
    assign rt_value = rt_hit_es ? es_result :
                      rt_hit_ms ? ms_result :
                      rt_hit_ws ? ws_data   : rf_rdata2;

    // load data not there yet
    assign load_use = ~es_result_valid & (uses_rs & rs_hit_es | uses_rt & rt_hit_es);
    assign ready_go = ~load_use;

endmodule

// File: logic/regfile.sv
`timescale 1ns/1ps
`include "decode_defs.svh"

module regfile (
    input  logic                  clk,
    input  logic                  we,
    input  decode_pkg::reg_addr_t waddr,
    input  decode_pkg::word_t     wdata,
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    output decode_pkg::word_t     rdata1,
    output decode_pkg::word_t     rdata2
);

    decode_pkg::word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin  // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    // asynchronous read
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: testbench/id_stage_checker.sv
`timescale 1ns/1ps

module id_stage_checker (
    input logic              clk,
    input logic              reset,
    input logic              ds_to_es_valid,
    input logic              es_allowin,
    input logic              br_taken,
    input logic              mem_re,
    input logic              mem_we,
    input decode_pkg::word_t ds_pc
);

    int unsigned fail_count = 0;  // read by the testbench at the end

    // stage comes out of reset empty
    reset_empties: assert property (@(posedge clk) reset |=> !ds_to_es_valid)
        else begin
            $error("ds_to_es_valid high in the cycle after reset");
            fail_count++;
        end

    taken_needs_valid: assert property (@(posedge clk) disable iff (reset)
        br_taken |-> ds_to_es_valid)
        else begin
            $error("br_taken without ds_to_es_valid");
            fail_count++;
        end

    load_store_exclusive: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> !(mem_re && mem_we))
        else begin
            $error("mem_re and mem_we both high");
            fail_count++;
        end

    // execute back-pressure freezes the stage
    hold_on_backpressure: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin |=> ds_to_es_valid && $stable(ds_pc))
        else begin
            $error("stage output changed while es_allowin was low");
            fail_count++;
        end

endmodule

bind id_stage id_stage_checker u_checker (
    .clk(clk), .reset(reset), .ds_to_es_valid(ds_to_es_valid), .es_allowin(es_allowin),
    .br_taken(br_taken), .mem_re(mem_re), .mem_we(mem_we), .ds_pc(ds_pc)
);

// File: testbench/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;
    import decode_pkg::*;

    localparam int MAX_CYCLES = 400;  // six tests of up to 40 cycles, reset, margin

    logic clk, reset, fs_to_ds_valid, es_allowin, es_result_valid, ws_we;
    word_t fs_inst, fs_pc, es_result, ms_result, ws_data;
    reg_addr_t es_dest, ms_dest, ws_dest;
    logic ds_allowin, ds_to_es_valid, src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8;
    logic gr_we, mem_re, mem_we, br_taken;
    alu_op_e alu_op;
    reg_addr_t dest;
    logic [15:0] imm;
    word_t rs_value, rt_value, ds_pc, br_target;
    int seed = 32'h9118_b768;
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycles = 0;

    id_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic word_t r_inst(funct_e fn, reg_addr_t rs, reg_addr_t rt,
                                     reg_addr_t rd, logic [4:0] sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t i_inst(opcode_e op, reg_addr_t rs, reg_addr_t rt,
                                     logic [15:0] val);
        return {op, rs, rt, val};
    endfunction

    function automatic word_t branch_dest(word_t pc, logic [15:0] off);
        return pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
    endfunction

    function automatic word_t jump_dest(word_t pc, logic [25:0] idx);
        word_t slot;
        slot = pc + 32'd4;
        return {slot[31:28], idx, 2'b00};
    endfunction

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_alu_op(input string name, input alu_op_e exp, input alu_op_e act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %s, actual %s", name, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic compare_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int start_errs);
        if (errors == start_errs) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, errors - start_errs);
            tests_failed++;
        end
    endtask

    // returns 2 ns after the falling edge of the cycle the instruction sits in decode
    task automatic send_inst(input word_t inst, input word_t pc);
        @(negedge clk);
        fs_to_ds_valid = 1'b1;
        fs_inst = inst;
        fs_pc = pc;
        #2;
        while (!ds_allowin) begin
            @(negedge clk);
            #2;
        end
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        #2;
    endtask

    task automatic write_reg(input reg_addr_t r, input word_t val);
        @(negedge clk);
        ws_we = 1'b1;
        ws_dest = r;
        ws_data = val;
        @(negedge clk);
        ws_we = 1'b0;
        ws_dest = '0;
    endtask

    task automatic check_decode(input string name, input word_t inst, input alu_op_e e_alu,
                                input reg_addr_t e_dest, input logic e_we, input logic e_re,
                                input logic e_mwe, input logic e_sa, input logic e_imm,
                                input logic [15:0] e_ival);
        send_inst(inst, 32'h0040_0000);
        compare_alu_op({name, " alu_op"}, e_alu, alu_op);
        compare_addr({name, " dest"}, e_dest, dest);
        compare_bit({name, " gr_we"}, e_we, gr_we);
        compare_bit({name, " mem_re"}, e_re, mem_re);
        compare_bit({name, " mem_we"}, e_mwe, mem_we);
        compare_bit({name, " src1_is_sa"}, e_sa, src1_is_sa);
        compare_bit({name, " src2_is_imm"}, e_imm, src2_is_imm);
        compare_word({name, " imm"}, word_t'(e_ival), word_t'(imm));
    endtask

    task automatic check_branch(input string name, input word_t inst, input word_t pc,
                                input logic exp_taken, input word_t exp_target);
        send_inst(inst, pc);
        compare_bit({name, " taken"}, exp_taken, br_taken);
        if (exp_taken) begin
            compare_word({name, " target"}, exp_target, br_target);
        end
    endtask

    task automatic test_reset();
        int start_errs;
        start_errs = errors;
        compare_bit("reset ds_to_es_valid", 1'b0, ds_to_es_valid);
        compare_bit("reset br_taken", 1'b0, br_taken);
        compare_bit("reset ds_allowin", 1'b1, ds_allowin);
        finish_test("reset", start_errs);
    endtask

    task automatic test_decode_table();
        int start_errs;
        start_errs = errors;
        check_decode("addu", r_inst(FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0),
                     ALU_ADD, 5'd3, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 16'h1821);
        check_decode("sll", r_inst(FN_SLL, 5'd0, 5'd5, 5'd4, 5'd7),
                     ALU_SLL, 5'd4, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 16'h21c0);
        check_decode("ori", i_inst(OP_ORI, 5'd7, 5'd6, 16'hbeef),
                     ALU_OR, 5'd6, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 16'hbeef);
        check_decode("lui", i_inst(OP_LUI, 5'd0, 5'd8, 16'h1234),
                     ALU_LUI, 5'd8, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 16'h1234);
        check_decode("lw", i_inst(OP_LW, 5'd10, 5'd9, 16'h0010),
                     ALU_ADD, 5'd9, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 16'h0010);
        // dest of sw comes from the rd bits of the offset
        check_decode("sw", i_inst(OP_SW, 5'd12, 5'd11, 16'hfffc),
                     ALU_ADD, 5'd31, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 16'hfffc);
        finish_test("decode_table", start_errs);
    endtask

    task automatic test_regfile();
        int start_errs;
        word_t vals [4];
        reg_addr_t sel [4];
        start_errs = errors;
        sel = '{5'd5, 5'd9, 5'd17, 5'd30};
        for (int i = 0; i < 4; i++) begin
            vals[i] = $random(seed);
            write_reg(sel[i], vals[i]);
        end
        write_reg(5'd0, $random(seed));  // must be dropped
        send_inst(r_inst(FN_ADDU, 5'd9, 5'd30, 5'd1, 5'd0), 32'h0040_0200);
        compare_word("regfile rs", vals[1], rs_value);
        compare_word("regfile rt", vals[3], rt_value);
        send_inst(r_inst(FN_ADDU, 5'd0, 5'd17, 5'd2, 5'd0), 32'h0040_0204);
        compare_word("regfile r0", 32'h0, rs_value);
        compare_word("regfile rt2", vals[2], rt_value);
        finish_test("regfile", start_errs);
    endtask

    task automatic test_forwarding();
        int start_errs;
        start_errs = errors;
        @(negedge clk);
        es_allowin = 1'b0;  // keep the addu in decode
        es_dest = 5'd13;
        es_result = 32'h1111_aaaa;
        ms_dest = 5'd13;
        ms_result = 32'h2222_bbbb;
        ws_we = 1'b1;
        ws_dest = 5'd13;
        ws_data = 32'h3333_cccc;
        send_inst(r_inst(FN_ADDU, 5'd13, 5'd0, 5'd1, 5'd0), 32'h0040_0400);
        compare_word("fwd execute", 32'h1111_aaaa, rs_value);
        @(negedge clk);
        es_dest = '0;
        #2;
        compare_word("fwd memory", 32'h2222_bbbb, rs_value);
        @(negedge clk);
        ms_dest = '0;
        ws_data = 32'h4444_dddd;  // regfile still holds the older word
        #2;
        compare_word("fwd writeback", 32'h4444_dddd, rs_value);
        @(negedge clk);
        ws_we = 1'b0;
        ws_dest = '0;
        es_allowin = 1'b1;
        finish_test("forwarding", start_errs);
    endtask

    task automatic test_stall_backpressure();
        int start_errs;
        start_errs = errors;
        @(negedge clk);
        es_dest = 5'd14;  // load in execute
        es_result_valid = 1'b0;
        send_inst(r_inst(FN_ADDU, 5'd14, 5'd0, 5'd2, 5'd0), 32'h0040_0500);
        repeat (3) begin
            compare_bit("stall ds_to_es_valid", 1'b0, ds_to_es_valid);
            compare_bit("stall ds_allowin", 1'b0, ds_allowin);
            @(negedge clk);
            #2;
        end
        @(negedge clk);
        es_result_valid = 1'b1;
        es_result = 32'h0bad_cafe;
        #2;
        compare_bit("load ready", 1'b1, ds_to_es_valid);
        compare_word("load data", 32'h0bad_cafe, rs_value);
        @(negedge clk);
        es_dest = '0;
        es_allowin = 1'b0;
        send_inst(i_inst(OP_ADDIU, 5'd0, 5'd3, 16'h0001), 32'h0040_0600);
        @(negedge clk);
        fs_to_ds_valid = 1'b1;  // next instruction waits behind it
        fs_inst = i_inst(OP_ADDIU, 5'd0, 5'd4, 16'h0002);
        fs_pc = 32'h0040_0604;
        repeat (3) begin
            #2;
            compare_word("held ds_pc", 32'h0040_0600, ds_pc);
            compare_bit("held ds_allowin", 1'b0, ds_allowin);
            @(negedge clk);
        end
        es_allowin = 1'b1;
        #2;
        compare_bit("released ds_allowin", 1'b1, ds_allowin);
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        #2;
        compare_word("next ds_pc", 32'h0040_0604, ds_pc);
        finish_test("stall_backpressure", start_errs);
    endtask

    task automatic test_branches();
        int start_errs;
        start_errs = errors;
        write_reg(5'd3, 32'h0000_0055);
        write_reg(5'd4, 32'h0000_0055);
        write_reg(5'd5, 32'h0000_0066);
        check_branch("beq eq", i_inst(OP_BEQ, 5'd3, 5'd4, 16'h0010), 32'h0040_0100,
                     1'b1, branch_dest(32'h0040_0100, 16'h0010));
        check_branch("beq ne", i_inst(OP_BEQ, 5'd3, 5'd5, 16'h0010), 32'h0040_0108,
                     1'b0, 32'h0);
        check_branch("bne ne", i_inst(OP_BNE, 5'd3, 5'd5, 16'hfff0), 32'h0040_0110,
                     1'b1, branch_dest(32'h0040_0110, 16'hfff0));
        check_branch("bne eq", i_inst(OP_BNE, 5'd3, 5'd4, 16'hfff0), 32'h0040_0118,
                     1'b0, 32'h0);
        // delay slot sits in the next 256 MB region
        check_branch("j", {OP_J, 26'h012_3456}, 32'hafff_fffc,
                     1'b1, jump_dest(32'hafff_fffc, 26'h012_3456));
        check_branch("jal", {OP_JAL, 26'h3ff_0001}, 32'h0040_0200,
                     1'b1, jump_dest(32'h0040_0200, 26'h3ff_0001));
        compare_addr("jal dest", 5'd31, dest);
        compare_bit("jal src1_is_pc", 1'b1, src1_is_pc);
        compare_bit("jal src2_is_8", 1'b1, src2_is_8);
        @(negedge clk);
        es_dest = 5'd5;  // jr target arrives from execute
        es_result = 32'h0080_0040;
        check_branch("jr", r_inst(FN_JR, 5'd5, 5'd0, 5'd0, 5'd0), 32'h0040_0300,
                     1'b1, 32'h0080_0040);
        @(negedge clk);
        es_dest = '0;
        finish_test("branches", start_errs);
    endtask

    initial begin
        reset = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_inst = '0;
        fs_pc = '0;
        es_allowin = 1'b1;
        es_dest = '0;
        es_result = '0;
        es_result_valid = 1'b1;
        ms_dest = '0;
        ms_result = '0;
        ws_we = 1'b0;
        ws_dest = '0;
        ws_data = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #2;
        test_reset();
        test_decode_table();
        test_regfile();
        test_forwarding();
        test_stall_backpressure();
        test_branches();
        @(negedge clk);
        $display("tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_passed, tests_failed, errors, uut.u_checker.fail_count);
        if (errors == 0 && uut.u_checker.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
